/* idStage.f */
design/idStagePkg.sv
design/idPipeReg.sv
design/regFile.sv
design/instrDecoder.sv
design/operandForward.sv
design/loadUseHazard.sv
design/idStage.sv
test/idStage_sva.sv
test/idStageTb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = idStageTb
FILELIST = idStage.f
OBJDIR   = obj_dir
PASS_MSG = Simulation finished: PASS

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# the pipeline status is the grep status, so a missing pass line fails the target
run: compile
	./$(OBJDIR)/V$(TOP) +verilator+error+limit+1000 | tee /dev/stderr | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJDIR)

/* test/idStageTb.sv */
/*
 * ID stage testbench
 * fills the register file through WB, then runs LCG stimulus while the
 * bound assertions check every cycle
 */
module idStageTb;
    import idStagePkg::*;

    // opcode and funct pools, the last entry of each is illegal
    localparam logic [5:0] opList [12] = '{opSpecial, opSpecial, opSpecial, opAddiu, opOri,
                                           opLui, opLw, opSw, opBeq, opJ, opJal, 6'h3f};
    localparam logic [5:0] fnList [6]  = '{fnAddu, fnSubu, fnAnd, fnOr, fnSlt, 6'h3f};

    logic                    clk;
    logic                    arstN;
    logic                    idFlush, idWr, idDisWr;
    logic [dataWidth-1:0]    ifInstr, ifPc, exeResult, memResult, mem2Result, wbResult;
    logic [regAddrWidth-1:0] exeDst, memDst, mem2Dst, wbDst;
    logic                    exeRegWr, memRegWr, mem2RegWr, wbRegWr;
    logic                    exeLoad, memLoad, mem2Load;
    logic [dataWidth-1:0]    idPc, idInstr, idImm32, idBusA, idBusB;
    aluOpT                   idAluOp;
    memOpT                   idMemOp;
    logic [regAddrWidth-1:0] idDst;
    logic                    idRegWr, idIsImmJump, idIllegal;
    logic                    exStall, mem1Stall, mem2Stall;
    logic [31:0]             seed;

    idStage uut (.*);

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // two steps per word, the low seed bits repeat too quickly to be used
    function automatic logic [31:0] nextRand();
        logic [15:0] hi;
        seed = seed * 32'd1664525 + 32'd1013904223;
        hi   = seed[31:16];
        seed = seed * 32'd1664525 + 32'd1013904223;
        return {hi, seed[31:16]};
    endfunction

    // register fields limited to r0..r7 so writers collide often
    function automatic logic [dataWidth-1:0] randInstr();
        logic [31:0] r;
        logic [5:0]  op;
        logic [15:0] low;
        r   = nextRand();
        op  = opList[r[11:8] % 4'd12];
        low = 16'(nextRand());
        if (op == opSpecial) low = {2'b00, r[14:12], 5'd0, fnList[r[18:16] % 3'd6]};
        if (r[23:20] == 4'h0) return '0; // plain nop now and then
        return {op, 2'b00, r[2:0], 2'b00, r[5:3], low};
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run aborted");
    endtask

    task automatic idleWriters();
        exeRegWr   <= 1'b0;
        memRegWr   <= 1'b0;
        mem2RegWr  <= 1'b0;
        wbRegWr    <= 1'b0;
        exeLoad    <= 1'b0;
        memLoad    <= 1'b0;
        mem2Load   <= 1'b0;
        exeDst     <= '0;
        memDst     <= '0;
        mem2Dst    <= '0;
        wbDst      <= '0;
        exeResult  <= '0;
        memResult  <= '0;
        mem2Result <= '0;
        wbResult   <= '0;
    endtask

    task automatic randWriters();
        logic [31:0] r;
        r = nextRand();
        exeRegWr   <= r[16];
        exeLoad    <= r[17] & r[18];
        exeDst     <= {2'b00, r[2:0]};
        memRegWr   <= r[19];
        memLoad    <= r[20] & r[21];
        memDst     <= {2'b00, r[5:3]};
        mem2RegWr  <= r[22];
        mem2Load   <= r[23] & r[24];
        mem2Dst    <= {2'b00, r[8:6]};
        wbRegWr    <= r[25];
        wbDst      <= {2'b00, r[11:9]};
        exeResult  <= nextRand();
        memResult  <= nextRand();
        mem2Result <= nextRand();
        wbResult   <= nextRand();
    endtask

    // a phase is done once its marker instruction sits in ID
    task automatic awaitInstr(input logic [dataWidth-1:0] want, input string phase);
        int cycles;
        cycles = 0;
        while (idInstr !== want) begin
            @(negedge clk);
            cycles++;
            if (cycles > 16) begin
                abortRun($sformatf("Timeout: the %s phase never latched its marker", phase));
            end
        end
    endtask

    always @(negedge clk) begin
        if (uut.sva.failed) begin
            abortRun($sformatf("Fail %s expected %h actual %h", uut.sva.failName,
                               uut.sva.failExp, uut.sva.failAct));
        end
    end

    initial begin
        logic [31:0] r;
        seed    = 32'hf729;
        arstN   = 1'b0;
        idFlush = 1'b0;
        idWr    = 1'b0;
        idDisWr = 1'b0;
        ifInstr = '0;
        ifPc    = '0;
        idleWriters();
        repeat (2) @(posedge clk);
        arstN <= 1'b1;

        for (int i = 1; i < 8; i++) begin // or ri, ri, r(i-1) while WB fills ri
            @(posedge clk);
            idWr     <= 1'b1;
            ifPc     <= 32'h0000_0400 + 32'(i * 4);
            ifInstr  <= {opSpecial, 5'(i), 5'(i - 1), 5'(i), 5'd0, fnOr};
            wbRegWr  <= 1'b1;
            wbDst    <= 5'(i);
            wbResult <= nextRand();
        end
        @(posedge clk);
        idleWriters();
        ifInstr <= {opLui, 5'd0, 5'd7, 16'hbeef};
        awaitInstr({opLui, 5'd0, 5'd7, 16'hbeef}, "register fill");

        for (int n = 0; n < 400; n++) begin
            @(posedge clk);
            r = nextRand();
            idFlush <= (r[19:16] == 4'h0);
            idWr    <= (r[21:20] != 2'b00);
            idDisWr <= (r[24:22] == 3'b000);
            ifPc    <= {r[31:2], 2'b00};
            ifInstr <= randInstr();
            randWriters();
        end

        @(posedge clk);
        idFlush <= 1'b0;
        idWr    <= 1'b1;
        idDisWr <= 1'b0;
        ifInstr <= {opJ, 26'h0abcde};
        idleWriters();
        awaitInstr({opJ, 26'h0abcde}, "final drain");
        repeat (2) @(negedge clk); // last checks sample the drained instruction

        if (uut.sva.failed) begin
            abortRun("an assertion failed near the end of the run");
        end else begin
            $display("Simulation finished: PASS");
            $finish;
        end
    end

endmodule

/* test/idStage_sva.sv */
/*
 * ID stage assertions
 * shadow models of the IF/ID register and the register file, checked
 * against decode, forwarding, write disable and stalls every cycle
 */
module idStageSva (
    input logic                                clk,
    input logic                                arstN,
    input logic                                idFlush,
    input logic                                idWr,
    input logic                                idDisWr,
    input logic [idStagePkg::dataWidth-1:0]    ifInstr,
    input logic [idStagePkg::dataWidth-1:0]    ifPc,
    input logic [idStagePkg::dataWidth-1:0]    exeResult, memResult, mem2Result, wbResult,
    input logic [idStagePkg::regAddrWidth-1:0] exeDst, memDst, mem2Dst, wbDst,
    input logic                                exeRegWr, memRegWr, mem2RegWr, wbRegWr,
    input logic                                exeLoad, memLoad, mem2Load,
    input logic [idStagePkg::dataWidth-1:0]    idPc, idInstr, idImm32, idBusA, idBusB,
    input idStagePkg::aluOpT                   idAluOp,
    input idStagePkg::memOpT                   idMemOp,
    input logic [idStagePkg::regAddrWidth-1:0] idDst,
    input logic                                idRegWr, idIsImmJump, idIllegal,
    input logic                                exStall, mem1Stall, mem2Stall
);
    import idStagePkg::*;

    logic [dataWidth-1:0]    shRegs [0:31]; // what WB has written so far
    logic [dataWidth-1:0]    shInstr;
    logic [dataWidth-1:0]    shPc;
    logic [dataWidth-1:0]    expA;
    logic [dataWidth-1:0]    expB;
    logic [dataWidth-1:0]    expImm;
    logic [5:0]              opc;
    logic [regAddrWidth-1:0] rs;
    logic [regAddrWidth-1:0] rt;
    aluOpT                   expAlu;
    memOpT                   expMem;
    logic [regAddrWidth-1:0] expDst;
    logic                    expReg, expIll, expJmp, useRs, useRt;
    logic [2:0]              expStall;
    logic                    failed; // watched by the testbench
    string                   failName;
    logic [dataWidth-1:0]    failExp;
    logic [dataWidth-1:0]    failAct;

    initial failed = 1'b0;

    task automatic noteFail(input string name, input logic [dataWidth-1:0] exp,
                            input logic [dataWidth-1:0] act);
        failName = name;
        failExp  = exp;
        failAct  = act;
        failed   = 1'b1;
        $error("%s check failed", name);
    endtask

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            shInstr <= '0;
            shPc    <= '0;
            for (int i = 0; i < 32; i++) begin
                shRegs[i] <= '0;
            end
        end else begin
            if (idFlush) begin
                shInstr <= '0; // nop
                shPc    <= '0;
            end else if (idWr) begin
                shInstr <= ifInstr;
                shPc    <= ifPc;
            end
            if (wbRegWr && (wbDst != '0)) shRegs[wbDst] <= wbResult;
        end
    end

    // youngest writer wins, r0 never forwards
    function automatic logic [dataWidth-1:0] newest(input logic [regAddrWidth-1:0] src);
        if (src == '0) return '0;
        if (exeRegWr && (exeDst == src)) return exeResult;
        if (memRegWr && (memDst == src)) return memResult;
        if (mem2RegWr && (mem2Dst == src)) return mem2Result;
        if (wbRegWr && (wbDst == src)) return wbResult;
        return shRegs[src];
    endfunction

    function automatic logic loadHit(input logic load, input logic [regAddrWidth-1:0] dst);
        return load && (dst != '0) && ((useRs && (dst == rs)) || (useRt && (dst == rt)));
    endfunction

    assign opc      = idInstr[31:26];
    assign rs       = idInstr[25:21];
    assign rt       = idInstr[20:16];
    assign expA     = newest(rs);
    assign expB     = newest(rt);
    assign expStall = {loadHit(exeLoad, exeDst), loadHit(memLoad, memDst),
                       loadHit(mem2Load, mem2Dst)};

    always_comb begin
        expAlu = aluNop;
        expMem = memNone;
        expReg = 1'b0;
        expDst = '0;
        expImm = {16'h0000, idInstr[15:0]}; // zero extension by default
        expIll = 1'b0;
        expJmp = 1'b0;
        useRs  = 1'b0;
        useRt  = 1'b0;
        case (opc)
            opSpecial: begin
                case (idInstr[5:0])
                    fnAddu:  expAlu = aluAdd;
                    fnSubu:  expAlu = aluSub;
                    fnAnd:   expAlu = aluAnd;
                    fnOr:    expAlu = aluOr;
                    fnSlt:   expAlu = aluSlt;
                    default: expIll = (idInstr != '0); // all zero is the nop
                endcase
                if (expAlu != aluNop) begin
                    expReg = 1'b1;
                    expDst = idInstr[15:11];
                    useRs  = 1'b1;
                    useRt  = 1'b1;
                end
            end
            opAddiu, opLw, opSw, opBeq: begin
                expImm = {{16{idInstr[15]}}, idInstr[15:0]};
                expAlu = (opc == opBeq) ? aluSub : aluAdd;
                expReg = (opc == opAddiu) || (opc == opLw);
                expDst = expReg ? rt : '0;
                expMem = (opc == opLw) ? memLoadWord : (opc == opSw) ? memStoreWord : memNone;
                useRs  = 1'b1;
                useRt  = (opc == opSw) || (opc == opBeq);
            end
            opOri: begin
                expAlu = aluOr;
                expReg = 1'b1;
                expDst = rt;
                useRs  = 1'b1;
            end
            opLui: begin
                expAlu = aluLui;
                expReg = 1'b1;
                expDst = rt;
                expImm = {idInstr[15:0], 16'h0000};
            end
            opJ:     expJmp = 1'b1;
            opJal: begin
                expJmp = 1'b1;
                expReg = 1'b1;
                expDst = linkReg;
            end
            default: expIll = 1'b1;
        endcase
    end

    aPipeInstr: assert property (@(posedge clk) disable iff (!arstN) idInstr == shInstr)
        else noteFail("pipeline instruction", $sampled(shInstr), $sampled(idInstr));
    aPipePc: assert property (@(posedge clk) disable iff (!arstN) idPc == shPc)
        else noteFail("pipeline pc", $sampled(shPc), $sampled(idPc));
    aBusA: assert property (@(posedge clk) disable iff (!arstN) idBusA == expA)
        else noteFail("busA", $sampled(expA), $sampled(idBusA));
    aBusB: assert property (@(posedge clk) disable iff (!arstN) idBusB == expB)
        else noteFail("busB", $sampled(expB), $sampled(idBusB));
    aDecode: assert property (@(posedge clk) disable iff (!arstN)
            {idAluOp, idDst, idIllegal, idIsImmJump} == {expAlu, expDst, expIll, expJmp})
        else noteFail("decode", dataWidth'($sampled({expAlu, expDst, expIll, expJmp})),
                      dataWidth'($sampled({idAluOp, idDst, idIllegal, idIsImmJump})));
    aImm: assert property (@(posedge clk) disable iff (!arstN) idImm32 == expImm)
        else noteFail("immediate", $sampled(expImm), $sampled(idImm32));
    aWrDisable: assert property (@(posedge clk) disable iff (!arstN)
            {idRegWr, idMemOp} == (idDisWr ? {1'b0, memNone} : {expReg, expMem}))
        else noteFail("write enables",
                      dataWidth'($sampled(idDisWr ? {1'b0, memNone} : {expReg, expMem})),
                      dataWidth'($sampled({idRegWr, idMemOp})));
    aStall: assert property (@(posedge clk) disable iff (!arstN)
            {exStall, mem1Stall, mem2Stall} == expStall)
        else noteFail("load-use stall", dataWidth'($sampled(expStall)),
                      dataWidth'($sampled({exStall, mem1Stall, mem2Stall})));

endmodule

bind idStage idStageSva sva (.*);

/* design/idStage.sv */
/*
 * Instruction decode stage
 * latches the fetched instruction, decodes it, reads and forwards both
 * operands and flags load-use hazards against EXE, MEM and MEM2
 */
module idStage (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                idFlush,
    input  logic                                idWr,
    input  logic                                idDisWr,
    input  logic [idStagePkg::dataWidth-1:0]    ifInstr,
    input  logic [idStagePkg::dataWidth-1:0]    ifPc,
    input  logic [idStagePkg::dataWidth-1:0]    exeResult,
    input  logic [idStagePkg::regAddrWidth-1:0] exeDst,
    input  logic                                exeRegWr,
    input  logic                                exeLoad,
    input  logic [idStagePkg::dataWidth-1:0]    memResult,
    input  logic [idStagePkg::regAddrWidth-1:0] memDst,
    input  logic                                memRegWr,
    input  logic                                memLoad,
    input  logic [idStagePkg::dataWidth-1:0]    mem2Result,
    input  logic [idStagePkg::regAddrWidth-1:0] mem2Dst,
    input  logic                                mem2RegWr,
    input  logic                                mem2Load,
    input  logic [idStagePkg::dataWidth-1:0]    wbResult,
    input  logic [idStagePkg::regAddrWidth-1:0] wbDst,
    input  logic                                wbRegWr,
    output logic [idStagePkg::dataWidth-1:0]    idPc,
    output logic [idStagePkg::dataWidth-1:0]    idInstr,
    output logic [idStagePkg::dataWidth-1:0]    idImm32,
    output logic [idStagePkg::dataWidth-1:0]    idBusA,
    output logic [idStagePkg::dataWidth-1:0]    idBusB,
    output idStagePkg::aluOpT                   idAluOp,
    output idStagePkg::memOpT                   idMemOp,
    output logic                                idRegWr,
    output logic [idStagePkg::regAddrWidth-1:0] idDst,
    output logic                                idIsImmJump,
    output logic                                idIllegal,
    output logic                                exStall,
    output logic                                mem1Stall,
    output logic                                mem2Stall
);
    import idStagePkg::*;

    logic [regAddrWidth-1:0] rsAddr;
    logic [regAddrWidth-1:0] rtAddr;
    logic [dataWidth-1:0]    rfRsData; // raw array reads
    logic [dataWidth-1:0]    rfRtData;
    memOpT                   decMemOp;
    logic                    decRegWr;
    logic                    readsRs;
    logic                    readsRt;

    assign rsAddr = idInstr[25:21];
    assign rtAddr = idInstr[20:16];

    // write disable kills the side effects only
    assign idRegWr = idDisWr ? 1'b0 : decRegWr;
    assign idMemOp = idDisWr ? memNone : decMemOp;

    idPipeReg uPipeReg (
        .clk     (clk),
        .arstN   (arstN),
        .idFlush (idFlush),
        .idWr    (idWr),
        .ifInstr (ifInstr),
        .ifPc    (ifPc),
        .instr   (idInstr),
        .pc      (idPc)
    );

    regFile uRegFile (
        .clk    (clk),
        .arstN  (arstN),
        .wrEn   (wbRegWr),
        .wrAddr (wbDst),
        .wrData (wbResult),
        .rsAddr (rsAddr),
        .rtAddr (rtAddr),
        .rsData (rfRsData),
        .rtData (rfRtData)
    );

    instrDecoder uDecoder (
        .instr     (idInstr),
        .aluOp     (idAluOp),
        .memOp     (decMemOp),
        .regWr     (decRegWr),
        .dst       (idDst),
        .imm32     (idImm32),
        .readsRs   (readsRs),
        .readsRt   (readsRt),
        .isImmJump (idIsImmJump),
        .illegal   (idIllegal)
    );

    operandForward uForward (
        .rsAddr     (rsAddr),
        .rtAddr     (rtAddr),
        .rfRsData   (rfRsData),
        .rfRtData   (rfRtData),
        .exeResult  (exeResult),
        .exeDst     (exeDst),
        .exeRegWr   (exeRegWr),
        .memResult  (memResult),
        .memDst     (memDst),
        .memRegWr   (memRegWr),
        .mem2Result (mem2Result),
        .mem2Dst    (mem2Dst),
        .mem2RegWr  (mem2RegWr),
        .wbResult   (wbResult),
        .wbDst      (wbDst),
        .wbRegWr    (wbRegWr),
        .busA       (idBusA),
        .busB       (idBusB)
    );

    loadUseHazard uHazard (
        .rsAddr    (rsAddr),
        .rtAddr    (rtAddr),
        .readsRs   (readsRs),
        .readsRt   (readsRt),
        .exeLoad   (exeLoad),
        .exeDst    (exeDst),
        .memLoad   (memLoad),
        .memDst    (memDst),
        .mem2Load  (mem2Load),
        .mem2Dst   (mem2Dst),
        .exStall   (exStall),
        .mem1Stall (mem1Stall),
        .mem2Stall (mem2Stall)
    );

endmodule

/* design/loadUseHazard.sv */
/*
 * Load-use hazard detection
 * one stall per stage while a lw in EXE, MEM or MEM2 targets a register
 * the instruction in ID still has to read
 */
module loadUseHazard (
    input  logic [idStagePkg::regAddrWidth-1:0] rsAddr,
    input  logic [idStagePkg::regAddrWidth-1:0] rtAddr,
    input  logic                                readsRs,
    input  logic                                readsRt,
    input  logic                                exeLoad,
    input  logic [idStagePkg::regAddrWidth-1:0] exeDst,
    input  logic                                memLoad,
    input  logic [idStagePkg::regAddrWidth-1:0] memDst,
    input  logic                                mem2Load,
    input  logic [idStagePkg::regAddrWidth-1:0] mem2Dst,
    output logic                                exStall,
    output logic                                mem1Stall,
    output logic                                mem2Stall
);
    import idStagePkg::*;

    function automatic logic loadHit(input logic                    load,
                                     input logic [regAddrWidth-1:0] dst,
                                     input logic [regAddrWidth-1:0] rs,
                                     input logic [regAddrWidth-1:0] rt,
                                     input logic                    useRs,
                                     input logic                    useRt);
        logic match;
        match = (useRs && (dst == rs)) || (useRt && (dst == rt));
        return load && (dst != '0) && match;
    endfunction

    assign exStall   = loadHit(exeLoad, exeDst, rsAddr, rtAddr, readsRs, readsRt);
    assign mem1Stall = loadHit(memLoad, memDst, rsAddr, rtAddr, readsRs, readsRt);
    assign mem2Stall = loadHit(mem2Load, mem2Dst, rsAddr, rtAddr, readsRs, readsRt);

endmodule

/* design/operandForward.sv */
/*
 * Operand forwarding
 * selects the newest pending writer of rs and rt among EXE, MEM, MEM2
 * and WB, falling back to the register file
 */
module operandForward (
    input  logic [idStagePkg::regAddrWidth-1:0] rsAddr,
    input  logic [idStagePkg::regAddrWidth-1:0] rtAddr,
    input  logic [idStagePkg::dataWidth-1:0]    rfRsData,
    input  logic [idStagePkg::dataWidth-1:0]    rfRtData,
    input  logic [idStagePkg::dataWidth-1:0]    exeResult,
    input  logic [idStagePkg::regAddrWidth-1:0] exeDst,
    input  logic                                exeRegWr,
    input  logic [idStagePkg::dataWidth-1:0]    memResult,
    input  logic [idStagePkg::regAddrWidth-1:0] memDst,
    input  logic                                memRegWr,
    input  logic [idStagePkg::dataWidth-1:0]    mem2Result,
    input  logic [idStagePkg::regAddrWidth-1:0] mem2Dst,
    input  logic                                mem2RegWr,
    input  logic [idStagePkg::dataWidth-1:0]    wbResult,
    input  logic [idStagePkg::regAddrWidth-1:0] wbDst,
    input  logic                                wbRegWr,
    output logic [idStagePkg::dataWidth-1:0]    busA,
    output logic [idStagePkg::dataWidth-1:0]    busB
);
    import idStagePkg::*;

    fwdSelT selA;
    fwdSelT selB;

    // r0 is never forwarded, so a matching dst is nonzero too
    function automatic fwdSelT pickSource(input logic [regAddrWidth-1:0] src);
        fwdSelT sel;
        sel = fwdRf;
        if (src != '0) begin
            if (exeRegWr && (exeDst == src))        sel = fwdExe;
            else if (memRegWr && (memDst == src))   sel = fwdMem;
            else if (mem2RegWr && (mem2Dst == src)) sel = fwdMem2;
            else if (wbRegWr && (wbDst == src))     sel = fwdWb;
        end
        return sel;
    endfunction

    function automatic logic [dataWidth-1:0] muxSource(input fwdSelT sel,
                                                       input logic [dataWidth-1:0] rfData);
        logic [dataWidth-1:0] data;
        case (sel)
            fwdExe:  data = exeResult;
            fwdMem:  data = memResult;
            fwdMem2: data = mem2Result;
            fwdWb:   data = wbResult;
            default: data = rfData;
        endcase
        return data;
    endfunction

    always_comb begin
        selA = pickSource(rsAddr);
        selB = pickSource(rtAddr);
        busA = muxSource(selA, rfRsData);
        busB = muxSource(selB, rfRtData);
    end

endmodule

/* design/instrDecoder.sv */
/*
 * Instruction decoder
 * turns opcode and funct into ALU, memory and write-back controls,
 * picks the destination and extends the 16-bit immediate
 */
module instrDecoder (
    input  logic [idStagePkg::dataWidth-1:0]    instr,
    output idStagePkg::aluOpT                   aluOp,
    output idStagePkg::memOpT                   memOp,
    output logic                                regWr,
    output logic [idStagePkg::regAddrWidth-1:0] dst,
    output logic [idStagePkg::dataWidth-1:0]    imm32,
    output logic                                readsRs,
    output logic                                readsRt,
    output logic                                isImmJump,
    output logic                                illegal
);
    import idStagePkg::*;

    opcodeT                  opcode;
    functT                   funct;
    logic [regAddrWidth-1:0] rt;
    logic [regAddrWidth-1:0] rd;
    logic [15:0]             imm16;
    extOpT                   extOp;

    assign opcode = opcodeT'(instr[31:26]);
    assign funct  = functT'(instr[5:0]);
    assign rt     = instr[20:16];
    assign rd     = instr[15:11];
    assign imm16  = instr[15:0];

    always_comb begin
        aluOp     = aluNop;
        memOp     = memNone;
        regWr     = 1'b0;
        dst       = '0;
        extOp     = extZero;
        readsRs   = 1'b0;
        readsRt   = 1'b0;
        isImmJump = 1'b0;
        illegal   = 1'b0;
        case (opcode)
            opSpecial: begin
                if (instr != '0) begin // all zero is the nop, nothing to do
                    regWr   = 1'b1;
                    dst     = rd;
                    readsRs = 1'b1;
                    readsRt = 1'b1;
                    case (funct)
                        fnAddu:  aluOp = aluAdd;
                        fnSubu:  aluOp = aluSub;
                        fnAnd:   aluOp = aluAnd;
                        fnOr:    aluOp = aluOr;
                        fnSlt:   aluOp = aluSlt;
                        default: begin
                            regWr   = 1'b0;
                            dst     = '0;
                            readsRs = 1'b0;
                            readsRt = 1'b0;
                            illegal = 1'b1;
                        end
                    endcase
                end
            end
            opAddiu: begin
                aluOp   = aluAdd;
                regWr   = 1'b1;
                dst     = rt;
                extOp   = extSign;
                readsRs = 1'b1;
            end
            opOri: begin
                aluOp   = aluOr;
                regWr   = 1'b1;
                dst     = rt;
                readsRs = 1'b1; // zero extended
            end
            opLui: begin
                aluOp = aluLui;
                regWr = 1'b1;
                dst   = rt;
                extOp = extUpper;
            end
            opLw: begin
                aluOp   = aluAdd; // base + offset
                memOp   = memLoadWord;
                regWr   = 1'b1;
                dst     = rt;
                extOp   = extSign;
                readsRs = 1'b1;
            end
            opSw: begin
                aluOp   = aluAdd;
                memOp   = memStoreWord;
                extOp   = extSign;
                readsRs = 1'b1;
                readsRt = 1'b1; // store data
            end
            opBeq: begin
                aluOp   = aluSub; // compare rs and rt
                extOp   = extSign;
                readsRs = 1'b1;
                readsRt = 1'b1;
            end
            opJ:     isImmJump = 1'b1;
            opJal: begin
                isImmJump = 1'b1;
                regWr     = 1'b1;
                dst       = linkReg;
            end
            default: illegal = 1'b1;
        endcase
    end

    // immediate extension
    always_comb begin
        imm32 = {{(dataWidth-16){1'b0}}, imm16};
        case (extOp)
            extSign:  imm32 = {{(dataWidth-16){imm16[15]}}, imm16};
            extUpper: imm32 = {imm16, {(dataWidth-16){1'b0}}};
            default:  imm32 = {{(dataWidth-16){1'b0}}, imm16};
        endcase
    end

endmodule

/* design/regFile.sv */
/*
 * Register file
 * 32 x 32 with one write port from WB and two combinational read ports,
 * register 0 is hardwired to zero
 */
module regFile (
    input  logic                                clk,
    input  logic                                arstN,
    input  logic                                wrEn,
    input  logic [idStagePkg::regAddrWidth-1:0] wrAddr,
    input  logic [idStagePkg::dataWidth-1:0]    wrData,
    input  logic [idStagePkg::regAddrWidth-1:0] rsAddr,
    input  logic [idStagePkg::regAddrWidth-1:0] rtAddr,
    output logic [idStagePkg::dataWidth-1:0]    rsData,
    output logic [idStagePkg::dataWidth-1:0]    rtData
);
    import idStagePkg::*;

    localparam int regCount = 2 ** regAddrWidth;

    logic [dataWidth-1:0] regs [1:regCount-1]; // no storage for r0

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 1; i < regCount; i++) begin
                regs[i] <= '0;
            end
        end else if (wrEn && (wrAddr != '0)) begin
            regs[wrAddr] <= wrData;
        end
    end

    // same-cycle WB data reaches ID through the forwarding unit
    assign rsData = (rsAddr == '0) ? '0 : regs[rsAddr];
    assign rtData = (rtAddr == '0) ? '0 : regs[rtAddr];

endmodule

/* design/idPipeReg.sv */
/*
 * IF/ID pipeline register
 * holds the fetched instruction and PC, flush inserts a nop
 */
module idPipeReg (
    input  logic                             clk,
    input  logic                             arstN,
    input  logic                             idFlush,
    input  logic                             idWr,
    input  logic [idStagePkg::dataWidth-1:0] ifInstr,
    input  logic [idStagePkg::dataWidth-1:0] ifPc,
    output logic [idStagePkg::dataWidth-1:0] instr,
    output logic [idStagePkg::dataWidth-1:0] pc
);
    import idStagePkg::*;

    // sll r0, r0, 0
    localparam logic [dataWidth-1:0] nopInstr = '0;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            instr <= nopInstr;
            pc    <= '0;
        end else if (idFlush) begin // flush wins over write
            instr <= nopInstr;
            pc    <= '0;
        end else if (idWr) begin
            instr <= ifInstr;
            pc    <= ifPc;
        end
        // idWr low: hold for the stall
    end

endmodule

/* design/idStagePkg.sv */
/*
 * ID stage package
 * word and register index widths, opcode and funct encodings, and the
 * control enums shared by the decode stage
 */
package idStagePkg;

    localparam int dataWidth    = 32;
    localparam int regAddrWidth = 5;

    localparam logic [regAddrWidth-1:0] linkReg = 5'd31; // jal return address

    // primary opcode field, instr[31:26]
    typedef enum logic [5:0] {
        opSpecial = 6'b000000,
        opJ       = 6'b000010,
        opJal     = 6'b000011,
        opBeq     = 6'b000100,
        opAddiu   = 6'b001001,
        opOri     = 6'b001101,
        opLui     = 6'b001111,
        opLw      = 6'b100011,
        opSw      = 6'b101011
    } opcodeT;

    // funct field of special, instr[5:0]
    typedef enum logic [5:0] {
        fnAddu = 6'b100001,
        fnSubu = 6'b100011,
        fnAnd  = 6'b100100,
        fnOr   = 6'b100101,
        fnSlt  = 6'b101010
    } functT;

    typedef enum logic [3:0] {
        aluNop, aluAdd, aluSub, aluAnd, aluOr, aluSlt, aluLui
    } aluOpT;

    typedef enum logic [1:0] {
        memNone, memLoadWord, memStoreWord
    } memOpT;

    typedef enum logic [1:0] {
        extZero, extSign, extUpper
    } extOpT;

    // operand source, newest writer first after the register file
    typedef enum logic [2:0] {
        fwdRf, fwdExe, fwdMem, fwdMem2, fwdWb
    } fwdSelT;

endpackage
